/* rtl/alut_pkg.sv */
//----------------------------------------------------------------------
// address lookup shared definitions
//----------------------------------------------------------------------

package alut_pkg;

   typedef logic [47:0] mac_t;        // station address
   typedef logic [1:0]  port_t;       // switch port number
   typedef logic [4:0]  port_mask_t;  // bit 4 is the switch itself
   typedef logic [31:0] time_t;       // time stamp or age
   typedef logic [1:0]  cmd_t;
   typedef logic [1:0]  idx_t;        // table index

   localparam int num_entries = 4;

   // command codes, 3 is ignored
   localparam cmd_t cmd_none  = 2'd0;
   localparam cmd_t cmd_learn = 2'd1;
   localparam cmd_t cmd_age   = 2'd2;

   // register offsets
   localparam logic [6:0] al_frm_d_addr_l   = 7'h00;
   localparam logic [6:0] al_frm_d_addr_u   = 7'h04;
   localparam logic [6:0] al_frm_s_addr_l   = 7'h08;
   localparam logic [6:0] al_frm_s_addr_u   = 7'h0C;
   localparam logic [6:0] al_s_port         = 7'h10;
   localparam logic [6:0] al_d_port         = 7'h14;
   localparam logic [6:0] al_mac_addr_l     = 7'h18;
   localparam logic [6:0] al_mac_addr_u     = 7'h1C;
   localparam logic [6:0] al_cur_time       = 7'h20;
   localparam logic [6:0] al_bb_age         = 7'h24;
   localparam logic [6:0] al_div_clk        = 7'h28;
   localparam logic [6:0] al_status         = 7'h2C;
   localparam logic [6:0] al_command        = 7'h30;
   localparam logic [6:0] al_lst_inv_addr_l = 7'h34;
   localparam logic [6:0] al_lst_inv_addr_u = 7'h38;
   localparam logic [6:0] al_lst_inv_port   = 7'h3C;

   typedef enum logic [1:0] {
      st_idle,          // waiting for a command
      st_chk_scan,      // learn, walking the table
      st_chk_update,    // learn, one write cycle
      st_age_scan       // age sweep
   } ctrl_state_t;

endpackage

/* rtl/alut_reg_bank.sv */
//----------------------------------------------------------------------
// address lookup APB register bank
//----------------------------------------------------------------------

module alut_reg_bank
(
   input  logic                   pclk27,
   input  logic                   n_p_reset27,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [6:0]             paddr,
   input  logic [31:0]            pwdata,
   input  alut_pkg::time_t        curr_time,
   input  logic                   add_check_active,  // status bit 0
   input  logic                   inval_in_prog,     // status bit 1
   input  logic                   reused,            // status bit 2
   input  alut_pkg::port_mask_t   d_port,
   input  alut_pkg::mac_t         lst_inv_addr_nrm,  // displaced by learn
   input  alut_pkg::port_t        lst_inv_port_nrm,
   input  alut_pkg::mac_t         lst_inv_addr_cmd,  // removed by age sweep
   input  alut_pkg::port_t        lst_inv_port_cmd,
   output alut_pkg::mac_t         mac_addr,          // switch own address
   output alut_pkg::mac_t         d_addr,
   output alut_pkg::mac_t         s_addr,
   output alut_pkg::port_t        s_port,
   output alut_pkg::time_t        best_bfr_age,
   output logic [7:0]             div_clk,
   output alut_pkg::cmd_t         command,           // one cycle pulse
   output logic [31:0]            prdata,
   output logic                   clear_reused
);

   logic            read_en;
   logic            write_en;
   alut_pkg::mac_t  lst_inv_addr;
   alut_pkg::port_t lst_inv_port;

   assign read_en  = psel & ~penable & ~pwrite;   // setup phase
   assign write_en = psel & penable & pwrite;     // access phase

   // status read acknowledges reuse, but not mid learn
   assign clear_reused = read_en & (paddr == alut_pkg::al_status) & ~add_check_active;

   //----------------------------------------------------------------------
   // read mux
   //----------------------------------------------------------------------
   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
         prdata <= '0;
      else if (read_en)
      begin
         case (paddr)
            alut_pkg::al_frm_d_addr_l   : prdata <= d_addr[31:0];
            alut_pkg::al_frm_d_addr_u   : prdata <= {16'd0, d_addr[47:32]};
            alut_pkg::al_frm_s_addr_l   : prdata <= s_addr[31:0];
            alut_pkg::al_frm_s_addr_u   : prdata <= {16'd0, s_addr[47:32]};
            alut_pkg::al_s_port         : prdata <= {30'd0, s_port};
            alut_pkg::al_d_port         : prdata <= {27'd0, d_port};
            alut_pkg::al_mac_addr_l     : prdata <= mac_addr[31:0];
            alut_pkg::al_mac_addr_u     : prdata <= {16'd0, mac_addr[47:32]};
            alut_pkg::al_cur_time       : prdata <= curr_time;
            alut_pkg::al_bb_age         : prdata <= best_bfr_age;
            alut_pkg::al_div_clk        : prdata <= {24'd0, div_clk};
            alut_pkg::al_status         : prdata <= {29'd0, reused, inval_in_prog,
                                                     add_check_active};
            alut_pkg::al_lst_inv_addr_l : prdata <= lst_inv_addr[31:0];
            alut_pkg::al_lst_inv_addr_u : prdata <= {16'd0, lst_inv_addr[47:32]};
            alut_pkg::al_lst_inv_port   : prdata <= {30'd0, lst_inv_port};
            default                     : prdata <= '0;   // command reads 0 too
         endcase
      end
      else
         prdata <= '0;   // bus idles at zero
   end

   //----------------------------------------------------------------------
   // writable registers
   //----------------------------------------------------------------------
   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
      begin
         d_addr       <= '0;
         s_addr       <= '0;
         s_port       <= '0;
         mac_addr     <= '0;
         best_bfr_age <= '1;       // nothing ages by default
         div_clk      <= '0;
      end
      else if (write_en)
      begin
         case (paddr)
            alut_pkg::al_frm_d_addr_l : d_addr[31:0]    <= pwdata;
            alut_pkg::al_frm_d_addr_u : d_addr[47:32]   <= pwdata[15:0];
            alut_pkg::al_frm_s_addr_l : s_addr[31:0]    <= pwdata;
            alut_pkg::al_frm_s_addr_u : s_addr[47:32]   <= pwdata[15:0];
            alut_pkg::al_s_port       : s_port          <= pwdata[1:0];
            alut_pkg::al_mac_addr_l   : mac_addr[31:0]  <= pwdata;
            alut_pkg::al_mac_addr_u   : mac_addr[47:32] <= pwdata[15:0];
            alut_pkg::al_bb_age       : best_bfr_age    <= pwdata;
            alut_pkg::al_div_clk      : div_clk         <= pwdata[7:0];
            default                   : ;
         endcase
      end
   end

   // command self clears one cycle after it was set
   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
         command <= alut_pkg::cmd_none;
      else if (command != alut_pkg::cmd_none)
         command <= alut_pkg::cmd_none;
      else if (write_en && (paddr == alut_pkg::al_command))
         command <= pwdata[1:0];
   end

   //----------------------------------------------------------------------
   // last invalidated entry, learn overwrite wins over age sweep
   //----------------------------------------------------------------------
   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

endmodule

/* rtl/alut_timer.sv */
//----------------------------------------------------------------------
// address lookup time base
//----------------------------------------------------------------------

module alut_timer
(
   input  logic            pclk27,
   input  logic            n_p_reset27,
   input  logic [7:0]      div_clk,      // tick every div_clk+1 cycles
   output alut_pkg::time_t curr_time
);

   logic [7:0] prescale;
   logic       tick;

   // >= so a lowered div_clk wraps at once
   assign tick = (prescale >= div_clk);

   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
      begin
         prescale  <= '0;
         curr_time <= '0;
      end
      else if (tick)
      begin
         prescale  <= '0;
         curr_time <= curr_time + alut_pkg::time_t'(1);
      end
      else
         prescale <= prescale + 8'd1;
   end

endmodule

/* rtl/alut_table.sv */
//----------------------------------------------------------------------
// address lookup entry store
//----------------------------------------------------------------------

module alut_table
(
   input  logic            pclk27,
   input  logic            n_p_reset27,
   input  alut_pkg::idx_t  rd_idx,
   input  logic            wr_en,       // write and mark valid
   input  logic            inval_en,    // clear valid
   input  alut_pkg::idx_t  wr_idx,
   input  alut_pkg::mac_t  wr_addr,
   input  alut_pkg::port_t wr_port,
   input  alut_pkg::time_t wr_time,
   output logic            rd_valid,
   output alut_pkg::mac_t  rd_addr,
   output alut_pkg::port_t rd_port,
   output alut_pkg::time_t rd_time
);

   alut_pkg::mac_t                   addr_mem [alut_pkg::num_entries];
   alut_pkg::port_t                  port_mem [alut_pkg::num_entries];
   alut_pkg::time_t                  time_mem [alut_pkg::num_entries];
   logic [alut_pkg::num_entries-1:0] valid;

   always_ff @(posedge pclk27)
   begin
      if (wr_en)
      begin
         addr_mem[wr_idx] <= wr_addr;
         port_mem[wr_idx] <= wr_port;
         time_mem[wr_idx] <= wr_time;
      end
   end

   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
         valid <= '0;                 // empty table
      else if (wr_en)
         valid[wr_idx] <= 1'b1;
      else if (inval_en)
         valid[wr_idx] <= 1'b0;
   end

   // combinational read port
   assign rd_valid = valid[rd_idx];
   assign rd_addr  = addr_mem[rd_idx];
   assign rd_port  = port_mem[rd_idx];
   assign rd_time  = time_mem[rd_idx];

endmodule

/* rtl/alut_ctrl.sv */
//----------------------------------------------------------------------
// address lookup learn and age controller
//----------------------------------------------------------------------

module alut_ctrl
(
   input  logic                 pclk27,
   input  logic                 n_p_reset27,
   input  alut_pkg::cmd_t       command,
   input  alut_pkg::mac_t       s_addr,
   input  alut_pkg::mac_t       d_addr,
   input  alut_pkg::mac_t       mac_addr,
   input  alut_pkg::port_t      s_port,
   input  alut_pkg::time_t      best_bfr_age,
   input  alut_pkg::time_t      curr_time,
   input  logic                 clear_reused,
   input  logic                 rd_valid,
   input  alut_pkg::mac_t       rd_addr,
   input  alut_pkg::port_t      rd_port,
   input  alut_pkg::time_t      rd_time,
   output logic                 add_check_active,
   output logic                 inval_in_prog,
   output logic                 reused,             // sticky
   output alut_pkg::port_mask_t d_port,
   output alut_pkg::mac_t       lst_inv_addr_nrm,
   output alut_pkg::port_t      lst_inv_port_nrm,
   output alut_pkg::mac_t       lst_inv_addr_cmd,
   output alut_pkg::port_t      lst_inv_port_cmd,
   output alut_pkg::idx_t       rd_idx,
   output logic                 wr_en,
   output logic                 inval_en,
   output alut_pkg::idx_t       wr_idx,
   output alut_pkg::mac_t       wr_addr,
   output alut_pkg::port_t      wr_port,
   output alut_pkg::time_t      wr_time
);

   alut_pkg::ctrl_state_t state;
   alut_pkg::idx_t        scan_idx;
   logic                  last_idx;
   logic                  expired;
   alut_pkg::time_t       age;
   logic                  s_hit, d_hit, free_found, old_found;   // trackers
   alut_pkg::idx_t        s_hit_idx, free_idx, old_idx;
   alut_pkg::port_t       d_hit_port;
   alut_pkg::time_t       old_time;
   alut_pkg::idx_t        upd_idx;                               // learn target
   alut_pkg::mac_t        inv_addr_q;
   alut_pkg::port_t       inv_port_q;

   assign last_idx = (scan_idx == alut_pkg::idx_t'(alut_pkg::num_entries - 1));
   assign age      = curr_time - rd_time;                       // unsigned wrap ok
   assign expired  = rd_valid && (age > best_bfr_age);

   assign upd_idx  = s_hit ? s_hit_idx : (free_found ? free_idx : old_idx);

   assign add_check_active = (state == alut_pkg::st_chk_scan) ||
                             (state == alut_pkg::st_chk_update);
   assign inval_in_prog    = (state == alut_pkg::st_age_scan);

   //----------------------------------------------------------------------
   // table steering
   //----------------------------------------------------------------------
   // update reads the victim so its address is at hand
   assign rd_idx   = (state == alut_pkg::st_chk_update) ? upd_idx : scan_idx;
   assign wr_idx   = inval_in_prog ? scan_idx : upd_idx;
   assign wr_en    = (state == alut_pkg::st_chk_update);
   assign inval_en = inval_in_prog && expired;
   assign wr_addr  = s_addr;
   assign wr_port  = s_port;
   assign wr_time  = curr_time;

   // current entry while it expires, else the held one
   assign lst_inv_addr_cmd = inval_en ? rd_addr : inv_addr_q;
   assign lst_inv_port_cmd = inval_en ? rd_port : inv_port_q;

   always_ff @(posedge pclk27 or negedge n_p_reset27)
   begin
      if (!n_p_reset27)
      begin
         state      <= alut_pkg::st_idle;
         scan_idx   <= '0;
         s_hit      <= 1'b0;
         d_hit      <= 1'b0;
         free_found <= 1'b0;
         old_found  <= 1'b0;
         reused     <= 1'b0;
         d_port     <= '0;
         inv_addr_q <= '0;
         inv_port_q <= '0;
      end
      else
      begin
         if (clear_reused)
            reused <= 1'b0;
         case (state)
            alut_pkg::st_idle:
            begin
               scan_idx   <= '0;
               s_hit      <= 1'b0;
               d_hit      <= 1'b0;
               free_found <= 1'b0;
               old_found  <= 1'b0;
               if (command == alut_pkg::cmd_learn)
                  state <= alut_pkg::st_chk_scan;
               else if (command == alut_pkg::cmd_age)
                  state <= alut_pkg::st_age_scan;
            end
            alut_pkg::st_chk_scan:
            begin
               scan_idx <= scan_idx + alut_pkg::idx_t'(1);
               if (rd_valid)
               begin
                  s_hit     <= s_hit | (rd_addr == s_addr);
                  d_hit     <= d_hit | (rd_addr == d_addr);
                  old_found <= 1'b1;
               end
               else
                  free_found <= 1'b1;
               if (last_idx)
                  state <= alut_pkg::st_chk_update;
            end
            alut_pkg::st_chk_update:
            begin
               state <= alut_pkg::st_idle;
               if (d_addr == mac_addr)
                  d_port <= 5'b10000;                         // for the switch
               else if (d_hit)
                  d_port <= 5'b00001 << d_hit_port;
               else
                  d_port <= {1'b0, ~(4'b0001 << s_port)};     // flood
               if (!s_hit && !free_found)
                  reused <= 1'b1;                             // oldest overwritten
            end
            alut_pkg::st_age_scan:
            begin
               scan_idx <= scan_idx + alut_pkg::idx_t'(1);
               if (expired)
               begin
                  inv_addr_q <= rd_addr;
                  inv_port_q <= rd_port;
               end
               if (last_idx)
                  state <= alut_pkg::st_idle;
            end
            default:
               state <= alut_pkg::st_idle;
         endcase
      end
   end

   // tracker payload, qualified by the flags above
   always_ff @(posedge pclk27)
   begin
      if (state == alut_pkg::st_chk_scan)
      begin
         if (rd_valid && rd_addr == s_addr && !s_hit)
            s_hit_idx <= scan_idx;
         if (rd_valid && rd_addr == d_addr)
            d_hit_port <= rd_port;
         if (!rd_valid && !free_found)
            free_idx <= scan_idx;                             // lowest free
         if (rd_valid && (!old_found || rd_time < old_time))
         begin
            old_idx  <= scan_idx;                             // lowest on ties
            old_time <= rd_time;
         end
      end
      if (wr_en && !s_hit && !free_found)
      begin
         lst_inv_addr_nrm <= rd_addr;                         // displaced entry
         lst_inv_port_nrm <= rd_port;
      end
   end

endmodule

/* rtl/alut_top.sv */
//----------------------------------------------------------------------
// address lookup unit top level
//----------------------------------------------------------------------

module alut_top
(
   input  logic        pclk27,
   input  logic        n_p_reset27,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   alut_pkg::mac_t       mac_addr, d_addr, s_addr;
   alut_pkg::port_t      s_port;
   alut_pkg::time_t      best_bfr_age, curr_time;
   logic [7:0]           div_clk;
   alut_pkg::cmd_t       command;
   logic                 clear_reused, add_check_active, inval_in_prog, reused;
   alut_pkg::port_mask_t d_port;
   alut_pkg::mac_t       lst_inv_addr_nrm, lst_inv_addr_cmd;
   alut_pkg::port_t      lst_inv_port_nrm, lst_inv_port_cmd;
   // table port
   alut_pkg::idx_t       rd_idx, wr_idx;
   logic                 rd_valid, wr_en, inval_en;
   alut_pkg::mac_t       rd_addr, wr_addr;
   alut_pkg::port_t      rd_port, wr_port;
   alut_pkg::time_t      rd_time, wr_time;

   alut_reg_bank u_reg_bank (.*);

   alut_timer u_timer
   (
      .pclk27      (pclk27),
      .n_p_reset27 (n_p_reset27),
      .div_clk     (div_clk),
      .curr_time   (curr_time)
   );

   alut_ctrl u_ctrl (.*);

   alut_table u_table (.*);

endmodule

/* sim/alut_tb.sv */
//----------------------------------------------------------------------
// address lookup unit testbench
//----------------------------------------------------------------------

module alut_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // step opcodes
   localparam int op_write     = 0;
   localparam int op_read      = 1;
   localparam int op_wait_idle = 2;   // poll status until bits 1:0 clear
   localparam int op_idle      = 3;   // dat holds the cycle count
   localparam int op_read_diff = 4;   // compare against the previous read
   localparam int max_polls    = 50;

   logic        pclk27;
   logic        n_p_reset27;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   // step table columns
   int          step_op   [$];
   bit          step_rnd  [$];        // random write, or readback of one
   logic [6:0]  step_ofs  [$];
   logic [31:0] step_dat  [$];
   logic [31:0] step_exp  [$];
   logic [31:0] step_msk  [$];
   string       step_name [$];

   logic [31:0] shadow [32];          // last random word per offset
   integer      seed = 61431;
   int          checks;
   int          errors;
   int          timeouts;
   int          i;
   logic [6:0]  ofs;
   logic [31:0] wdata;
   logic [31:0] rdata;
   logic [31:0] last_rd;

   alut_top uut
   (
      .pclk27      (pclk27),
      .n_p_reset27 (n_p_reset27),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata)
   );

   initial
   begin
      pclk27 = 1'b0;
      forever #5 pclk27 = ~pclk27;   // 10 ns period
   end

   //----------------------------------------------------------------------
   // bus cycles, one idle cycle after each
   //----------------------------------------------------------------------
   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(negedge pclk27);
      psel    = 1'b1;                 // setup phase
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk27);
      penable = 1'b1;                 // access, written on next edge
      @(negedge pclk27);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
      @(negedge pclk27);
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(negedge pclk27);
      penable = 1'b1;
      data    = prdata;               // registered in setup phase
      @(negedge pclk27);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         $display("error %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // status polls, last value returned
   task automatic poll_idle(input string name, output logic [31:0] status);
      int polls;
      read_reg(alut_pkg::al_status, status);
      polls = 1;
      while ((status[1:0] != 2'b00) && (polls < max_polls))
      begin
         read_reg(alut_pkg::al_status, status);
         polls++;
      end
      if (status[1:0] != 2'b00)
      begin
         $display("timeout in %s: unit still busy after %0d status reads", name, polls);
         timeouts++;
      end
   endtask

   //----------------------------------------------------------------------
   // step table
   //----------------------------------------------------------------------
   task automatic add_step(input int op, input bit rnd, input logic [6:0] addr,
                           input logic [31:0] dat, input logic [31:0] exp,
                           input logic [31:0] msk, input string name);
      step_op.push_back(op);
      step_rnd.push_back(rnd);
      step_ofs.push_back(addr);
      step_dat.push_back(dat);
      step_exp.push_back(exp);
      step_msk.push_back(msk);
      step_name.push_back(name);
   endtask

   // command write, then wait for the unit to go idle
   task automatic add_cmd(input alut_pkg::cmd_t cmd, input logic [31:0] exp,
                          input logic [31:0] msk, input string name);
      add_step(op_write, 1'b0, alut_pkg::al_command, {30'd0, cmd}, 0, 0, name);
      add_step(op_wait_idle, 1'b0, alut_pkg::al_status, 0, exp, msk, name);
   endtask

   task automatic build_steps;
      logic [6:0]  rb_ofs [9] = '{alut_pkg::al_frm_d_addr_l, alut_pkg::al_frm_d_addr_u,
                                  alut_pkg::al_frm_s_addr_l, alut_pkg::al_frm_s_addr_u,
                                  alut_pkg::al_s_port, alut_pkg::al_mac_addr_l,
                                  alut_pkg::al_mac_addr_u, alut_pkg::al_bb_age,
                                  alut_pkg::al_div_clk};
      logic [31:0] rb_msk [9] = '{32'hffff_ffff, 32'h0000_ffff, 32'hffff_ffff,
                                  32'h0000_ffff, 32'h0000_0003, 32'hffff_ffff,
                                  32'h0000_ffff, 32'hffff_ffff, 32'h0000_00ff};
      int          k;
      // reset values
      add_step(op_read, 1'b0, alut_pkg::al_bb_age, 0, 32'hffff_ffff, '1, "reset bb_age");
      add_step(op_read, 1'b0, alut_pkg::al_div_clk, 0, 0, '1, "reset div_clk");
      add_step(op_read, 1'b0, alut_pkg::al_status, 0, 0, '1, "reset status");
      add_step(op_read, 1'b0, alut_pkg::al_d_port, 0, 0, '1, "reset d_port");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_addr_l, 0, 0, '1, "reset inv addr l");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_addr_u, 0, 0, '1, "reset inv addr u");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_port, 0, 0, '1, "reset inv port");
      // random readback, mask is the field width
      for (k = 0; k < 9; k++)
      begin
         add_step(op_write, 1'b1, rb_ofs[k], 0, 0, 0, "readback");
         add_step(op_read, 1'b1, rb_ofs[k], 0, 0, rb_msk[k],
                  $sformatf("readback %02h", rb_ofs[k]));
      end
      add_step(op_read, 1'b0, alut_pkg::al_command, 0, 0, '1, "readback command");
      // replacement, one tick per cycle so stamps rise
      add_step(op_write, 1'b0, alut_pkg::al_div_clk, 0, 0, 0, "setup");
      add_step(op_write, 1'b0, alut_pkg::al_mac_addr_l, 32'h5e00_0001, 0, 0, "setup");
      add_step(op_write, 1'b0, alut_pkg::al_mac_addr_u, 32'h0000_02aa, 0, 0, "setup");
      add_step(op_write, 1'b0, alut_pkg::al_frm_s_addr_u, 32'h0000_0011, 0, 0, "setup");
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_u, 32'h0000_0011, 0, 0, "setup");
      add_step(op_write, 1'b0, alut_pkg::al_s_port, 32'd2, 0, 0, "setup");
      for (k = 1; k <= 4; k++)
      begin
         add_step(op_write, 1'b0, alut_pkg::al_frm_s_addr_l, 32'ha000_0000 + k, 0, 0, "fill");
         add_cmd(alut_pkg::cmd_learn, 0, 0, "fill");
      end
      add_step(op_write, 1'b0, alut_pkg::al_frm_s_addr_l, 32'ha000_0005, 0, 0, "replace");
      add_cmd(alut_pkg::cmd_learn, 32'h4, 32'h7, "replace reused set");   // table full
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_addr_l, 0, 32'ha000_0001, '1,
               "replace inv addr l");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_addr_u, 0, 32'h11, '1, "replace inv addr u");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_port, 0, 32'd2, '1, "replace inv port");
      add_step(op_read, 1'b0, alut_pkg::al_status, 0, 0, 32'h7, "replace reused cleared");
      // learn A from port 1
      add_step(op_write, 1'b0, alut_pkg::al_frm_s_addr_l, 32'hb000_000a, 0, 0, "learn");
      add_step(op_write, 1'b0, alut_pkg::al_s_port, 32'd1, 0, 0, "learn");
      add_cmd(alut_pkg::cmd_learn, 0, 0, "learn");
      // lookups from port 2
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_l, 32'hb000_000a, 0, 0, "lookup");
      add_step(op_write, 1'b0, alut_pkg::al_frm_s_addr_l, 32'hb000_000b, 0, 0, "lookup");
      add_step(op_write, 1'b0, alut_pkg::al_s_port, 32'd2, 0, 0, "lookup");
      add_cmd(alut_pkg::cmd_learn, 0, 0, "lookup");
      add_step(op_read, 1'b0, alut_pkg::al_d_port, 0, 32'h02, '1, "lookup known");
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_l, 32'h5e00_0001, 0, 0, "lookup");
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_u, 32'h0000_02aa, 0, 0, "lookup");
      add_cmd(alut_pkg::cmd_learn, 0, 0, "lookup");
      add_step(op_read, 1'b0, alut_pkg::al_d_port, 0, 32'h10, '1, "lookup switch");
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_l, 32'hc000_0c0c, 0, 0, "lookup");
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_u, 32'h0000_0011, 0, 0, "lookup");
      add_cmd(alut_pkg::cmd_learn, 0, 0, "lookup");
      add_step(op_read, 1'b0, alut_pkg::al_d_port, 0, 32'h0b, '1, "lookup unknown");
      // aging, every entry is far older than 20
      add_step(op_write, 1'b0, alut_pkg::al_bb_age, 32'd20, 0, 0, "age");
      add_step(op_idle, 1'b0, 0, 32'd60, 0, 0, "age");
      add_cmd(alut_pkg::cmd_age, 0, 0, "age");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_addr_l, 0, 32'ha000_0004, '1,
               "age inv addr l");                         // entry 3
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_addr_u, 0, 32'h11, '1, "age inv addr u");
      add_step(op_read, 1'b0, alut_pkg::al_lst_inv_port, 0, 32'd2, '1, "age inv port");
      add_step(op_write, 1'b0, alut_pkg::al_frm_d_addr_l, 32'ha000_0004, 0, 0, "age");
      add_step(op_write, 1'b0, alut_pkg::al_s_port, 32'd3, 0, 0, "age");
      add_cmd(alut_pkg::cmd_learn, 0, 0, "age");
      add_step(op_read, 1'b0, alut_pkg::al_d_port, 0, 32'h07, '1, "age flood");
      // time base, 8 cycles at div_clk 3 is two ticks
      add_step(op_write, 1'b0, alut_pkg::al_div_clk, 32'd3, 0, 0, "time");
      add_step(op_read, 1'b0, alut_pkg::al_cur_time, 0, 0, 0, "time");
      add_step(op_idle, 1'b0, 0, 32'd5, 0, 0, "time");    // read takes 3
      add_step(op_read_diff, 1'b0, alut_pkg::al_cur_time, 0, 32'd2, '1, "time delta");
   endtask

   task automatic run_step(input int idx);
      ofs = step_ofs[idx];
      case (step_op[idx])
         op_write:
         begin
            if (step_rnd[idx])
            begin
               wdata       = $random(seed);
               shadow[ofs[6:2]] = wdata;
            end
            else
               wdata = step_dat[idx];
            write_reg(ofs, wdata);
         end
         op_read:
         begin
            read_reg(ofs, rdata);
            if (step_rnd[idx])
               check_value(step_name[idx], shadow[ofs[6:2]] & step_msk[idx], rdata);
            else if (step_msk[idx] != 0)
               check_value(step_name[idx], step_exp[idx], rdata & step_msk[idx]);
            last_rd = rdata;
         end
         op_read_diff:
         begin
            read_reg(ofs, rdata);
            check_value(step_name[idx], step_exp[idx], (rdata - last_rd) & step_msk[idx]);
            last_rd = rdata;
         end
         op_wait_idle:
         begin
            poll_idle(step_name[idx], rdata);
            if (step_msk[idx] != 0)
               check_value(step_name[idx], step_exp[idx], rdata & step_msk[idx]);
         end
         op_idle:
            repeat (step_dat[idx]) @(negedge pclk27);
         default:
         begin
            $display("unknown step opcode at step %0d", idx);
            errors++;
         end
      endcase
   endtask

   //----------------------------------------------------------------------
   // main sequence
   //----------------------------------------------------------------------
   initial
   begin
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      n_p_reset27 = 1'b0;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      last_rd     = '0;
      build_steps();
      repeat (4) @(posedge pclk27);
      @(negedge pclk27);
      n_p_reset27 = 1'b1;
      for (i = 0; i < step_op.size(); i++)
         run_step(i);
      $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* filelist.f */
rtl/alut_pkg.sv
rtl/alut_reg_bank.sv
rtl/alut_timer.sv
rtl/alut_table.sv
rtl/alut_ctrl.sv
rtl/alut_top.sv
sim/alut_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the address lookup testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module alut_tb -f filelist.f -o alut_sim
./obj_dir/alut_sim | tee sim.log

if grep -qF '** FAIL **' sim.log; then
   exit 1
fi
exit 0
